// File: verilog/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and data widths
`define DC_ADDR_BITS      32
`define DC_WORD_BITS      32
`define DC_BLOCK_BITS     64

// cache geometry, 8 sets of 4 ways
`define DC_SET_COUNT      8
`define DC_SET_BITS       3
`define DC_WAY_COUNT      4
`define DC_WAY_BITS       2
`define DC_OFFSET_BITS    3

// address minus set and offset bits
`define DC_TAG_BITS       26

// miss buffer
`define DC_BUFFER_DEPTH   8
`define DC_BUFFER_BITS    3

// memory transaction tag, zero means none
`define DC_MEM_TAG_BITS   4
`define DC_ROB_BITS       5

`endif

// File: verilog/dcache_pkg.sv
package dcache_pkg;

    // load access size
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

    // command toward memory
    typedef enum logic {
        bus_none = 1'b0,
        bus_load = 1'b1
    } bus_command_t;

endpackage

// File: verilog/cache_array.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module cache_array (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`DC_ADDR_BITS-1:0]    lookup_addr,
    input  logic                        lookup_valid,
    input  logic                        fill_valid,
    input  logic [`DC_ADDR_BITS-1:0]    fill_addr,
    input  logic [`DC_WAY_BITS-1:0]     fill_way,
    input  logic [`DC_BLOCK_BITS-1:0]   fill_data,
    output logic                        hit,
    output logic [`DC_WAY_BITS-1:0]     hit_way,
    output logic [`DC_BLOCK_BITS-1:0]   hit_block
);

    // per set, per way storage
    logic [`DC_SET_COUNT-1:0][`DC_WAY_COUNT-1:0] valid_bits;
    logic [`DC_TAG_BITS-1:0]   tag_mem  [`DC_SET_COUNT][`DC_WAY_COUNT];
    logic [`DC_BLOCK_BITS-1:0] data_mem [`DC_SET_COUNT][`DC_WAY_COUNT];

    logic [`DC_SET_BITS-1:0] lookup_set;
    logic [`DC_TAG_BITS-1:0] lookup_tag;
    logic [`DC_SET_BITS-1:0] fill_set;
    logic [`DC_TAG_BITS-1:0] fill_tag;

    // address split: tag | set | offset
    assign lookup_set = lookup_addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign lookup_tag = lookup_addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
    assign fill_set   = fill_addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign fill_tag   = fill_addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];

    // compare all four ways of the set in parallel
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAY_COUNT; w++) begin
            if (lookup_valid && valid_bits[lookup_set][w]
                    && (tag_mem[lookup_set][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = w[`DC_WAY_BITS-1:0];
            end
        end
    end

    assign hit_block = data_mem[lookup_set][hit_way];

    // valid bits, all blocks invalid after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_valid) begin
            valid_bits[fill_set][fill_way] <= 1'b1;
        end
    end

    // tag and data written together on a fill
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_mem[fill_set][fill_way]  <= fill_tag;
            data_mem[fill_set][fill_way] <= fill_data;
        end
    end

endmodule

// File: verilog/plru_tree.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module plru_tree (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`DC_SET_BITS-1:0]     lookup_set,
    output logic [`DC_WAY_BITS-1:0]     victim_way,
    input  logic                        hit_update,
    input  logic [`DC_SET_BITS-1:0]     hit_set,
    input  logic [`DC_WAY_BITS-1:0]     hit_way,
    input  logic                        fill_update,
    input  logic [`DC_SET_BITS-1:0]     fill_set,
    input  logic [`DC_WAY_BITS-1:0]     fill_way
);

    // bit 0 root (0 = left pair), bit 1 ways 0/1, bit 2 ways 2/3
    logic [`DC_SET_COUNT-1:0][2:0] trees;
    logic [2:0] lookup_tree;

    // point every node on the used way's path away from it
    function automatic logic [2:0] touch(input logic [2:0] tree,
                                         input logic [`DC_WAY_BITS-1:0] way);
        logic [2:0] next;
        next    = tree;
        next[0] = ~way[1];
        if (way[1]) begin
            next[2] = ~way[0];
        end else begin
            next[1] = ~way[0];
        end
        return next;
    endfunction

    assign lookup_tree = trees[lookup_set];

    // follow the pointers down to a leaf
    always_comb begin
        if (lookup_tree[0]) begin
            victim_way = {1'b1, lookup_tree[2]};
        end else begin
            victim_way = {1'b0, lookup_tree[1]};
        end
    end

    // hit wins over fill
    always_ff @(posedge clock) begin
        if (reset) begin
            trees <= '0;
        end else if (hit_update) begin
            trees[hit_set] <= touch(trees[hit_set], hit_way);
        end else if (fill_update) begin
            trees[fill_set] <= touch(trees[fill_set], fill_way);
        end
    end

endmodule

// File: verilog/miss_buffer.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module miss_buffer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            enqueue,
    input  logic [`DC_ADDR_BITS-1:0]        load_addr,
    input  dcache_pkg::mem_size_t           load_size,
    input  logic                            load_signed,
    input  logic [`DC_ROB_BITS-1:0]         load_rob,
    input  logic [`DC_WAY_BITS-1:0]         victim_way,
    input  logic                            hold_retire,
    output logic                            buffer_full,
    output dcache_pkg::bus_command_t        mem_command,
    output logic [`DC_ADDR_BITS-1:0]        mem_addr,
    input  logic [`DC_MEM_TAG_BITS-1:0]     mem_response,
    input  logic [`DC_BLOCK_BITS-1:0]       mem_data,
    input  logic [`DC_MEM_TAG_BITS-1:0]     mem_tag,
    output logic                            retire_valid,
    output logic [`DC_ADDR_BITS-1:0]        retire_addr,
    output dcache_pkg::mem_size_t           retire_size,
    output logic                            retire_signed,
    output logic [`DC_ROB_BITS-1:0]         retire_rob,
    output logic [`DC_WAY_BITS-1:0]         retire_way,
    output logic [`DC_BLOCK_BITS-1:0]       retire_block
);

    typedef struct packed {
        logic [`DC_ADDR_BITS-1:0]    addr;
        dcache_pkg::mem_size_t       size;
        logic                        is_signed;
        logic [`DC_ROB_BITS-1:0]     rob;
        logic [`DC_WAY_BITS-1:0]     way;
        logic [`DC_MEM_TAG_BITS-1:0] mem_tag;
        logic [`DC_BLOCK_BITS-1:0]   data;
    } entry_t;

    entry_t entries [`DC_BUFFER_DEPTH];

    // per entry status
    logic [`DC_BUFFER_DEPTH-1:0] valid;
    logic [`DC_BUFFER_DEPTH-1:0] issued;
    logic [`DC_BUFFER_DEPTH-1:0] done;

    logic [`DC_BUFFER_BITS-1:0] head_ptr;
    logic [`DC_BUFFER_BITS-1:0] send_ptr;
    logic [`DC_BUFFER_BITS-1:0] tail_ptr;
    logic [`DC_BUFFER_BITS:0]   count;

    logic push;
    logic pending_send;
    logic accepted;
    logic [`DC_BUFFER_DEPTH-1:0] returned;

    assign buffer_full  = (count == `DC_BUFFER_DEPTH);
    assign push         = enqueue && !buffer_full && !flush;

    // oldest entry not yet accepted by memory
    assign pending_send = valid[send_ptr] && !issued[send_ptr];
    assign accepted     = pending_send && (mem_response != '0);

    assign mem_command = pending_send ? dcache_pkg::bus_load : dcache_pkg::bus_none;
    assign mem_addr    = pending_send
                       ? {entries[send_ptr].addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS],
                          {`DC_OFFSET_BITS{1'b0}}}
                       : '0;

    // tagged return matches any waiting entry
    always_comb begin
        for (int i = 0; i < `DC_BUFFER_DEPTH; i++) begin
            returned[i] = valid[i] && issued[i] && !done[i]
                          && (mem_tag != '0) && (entries[i].mem_tag == mem_tag);
        end
    end

    // head leaves when done, unless a hit owns the result port
    assign retire_valid  = valid[head_ptr] && done[head_ptr] && !hold_retire && !flush;
    assign retire_addr   = entries[head_ptr].addr;
    assign retire_size   = entries[head_ptr].size;
    assign retire_signed = entries[head_ptr].is_signed;
    assign retire_rob    = entries[head_ptr].rob;
    assign retire_way    = entries[head_ptr].way;
    assign retire_block  = entries[head_ptr].data;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid    <= '0;
            issued   <= '0;
            done     <= '0;
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                valid[tail_ptr]  <= 1'b1;
                issued[tail_ptr] <= 1'b0;
                done[tail_ptr]   <= 1'b0;
                tail_ptr         <= tail_ptr + 1'b1;
            end
            if (accepted) begin
                issued[send_ptr] <= 1'b1;
                send_ptr         <= send_ptr + 1'b1;
            end
            for (int i = 0; i < `DC_BUFFER_DEPTH; i++) begin
                if (returned[i]) begin
                    done[i] <= 1'b1;
                end
            end
            if (retire_valid) begin
                valid[head_ptr] <= 1'b0;
                head_ptr        <= head_ptr + 1'b1;
            end
            count <= count + push - retire_valid;
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail_ptr].addr      <= load_addr;
            entries[tail_ptr].size      <= load_size;
            entries[tail_ptr].is_signed <= load_signed;
            entries[tail_ptr].rob       <= load_rob;
            entries[tail_ptr].way       <= victim_way;
        end
        if (accepted) begin
            entries[send_ptr].mem_tag <= mem_response;
        end
        for (int i = 0; i < `DC_BUFFER_DEPTH; i++) begin
            if (returned[i]) begin
                entries[i].data <= mem_data;
            end
        end
    end

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module load_align (
    input  logic                        hit,
    input  logic [`DC_ADDR_BITS-1:0]    load_addr,
    input  dcache_pkg::mem_size_t       load_size,
    input  logic                        load_signed,
    input  logic [`DC_ROB_BITS-1:0]     load_rob,
    input  logic [`DC_BLOCK_BITS-1:0]   hit_block,
    input  logic                        retire_valid,
    input  logic [`DC_ADDR_BITS-1:0]    retire_addr,
    input  dcache_pkg::mem_size_t       retire_size,
    input  logic                        retire_signed,
    input  logic [`DC_ROB_BITS-1:0]     retire_rob,
    input  logic [`DC_BLOCK_BITS-1:0]   retire_block,
    output logic                        result_valid,
    output logic [`DC_WORD_BITS-1:0]    result_value,
    output logic [`DC_ROB_BITS-1:0]     result_rob
);

    logic [`DC_OFFSET_BITS-1:0] sel_offset;
    dcache_pkg::mem_size_t      sel_size;
    logic                       sel_signed;
    logic [`DC_BLOCK_BITS-1:0]  sel_block;
    logic [`DC_BLOCK_BITS-1:0]  shifted;

    // hit source first, then the retiring miss
    assign sel_offset = hit ? load_addr[`DC_OFFSET_BITS-1:0]
                            : retire_addr[`DC_OFFSET_BITS-1:0];
    assign sel_size   = hit ? load_size   : retire_size;
    assign sel_signed = hit ? load_signed : retire_signed;
    assign sel_block  = hit ? hit_block   : retire_block;

    // bring the addressed byte down to bit 0
    assign shifted = sel_block >> {sel_offset, 3'b000};

    assign result_valid = hit || retire_valid;
    assign result_rob   = hit ? load_rob : (retire_valid ? retire_rob : '0);

    always_comb begin
        result_value = '0;
        if (result_valid) begin
            case (sel_size)
                dcache_pkg::size_byte:
                    result_value = {{(`DC_WORD_BITS-8){sel_signed & shifted[7]}},
                                    shifted[7:0]};
                dcache_pkg::size_half:
                    result_value = {{(`DC_WORD_BITS-16){sel_signed & shifted[15]}},
                                    shifted[15:0]};
                default:
                    result_value = shifted[`DC_WORD_BITS-1:0];
            endcase
        end
    end

endmodule

// File: verilog/dcache.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            load_valid,
    input  logic [`DC_ADDR_BITS-1:0]        load_addr,
    input  dcache_pkg::mem_size_t           load_size,
    input  logic                            load_signed,
    input  logic [`DC_ROB_BITS-1:0]         load_rob,
    output logic                            buffer_full,
    output dcache_pkg::bus_command_t        mem_command,
    output logic [`DC_ADDR_BITS-1:0]        mem_addr,
    input  logic [`DC_MEM_TAG_BITS-1:0]     mem_response,
    input  logic [`DC_BLOCK_BITS-1:0]       mem_data,
    input  logic [`DC_MEM_TAG_BITS-1:0]     mem_tag,
    output logic                            result_valid,
    output logic [`DC_WORD_BITS-1:0]        result_value,
    output logic [`DC_ROB_BITS-1:0]         result_rob
);

    logic                        hit;
    logic [`DC_WAY_BITS-1:0]     hit_way;
    logic [`DC_BLOCK_BITS-1:0]   hit_block;
    logic [`DC_WAY_BITS-1:0]     victim_way;
    logic                        miss;

    logic                        retire_valid;
    logic [`DC_ADDR_BITS-1:0]    retire_addr;
    dcache_pkg::mem_size_t       retire_size;
    logic                        retire_signed;
    logic [`DC_ROB_BITS-1:0]     retire_rob;
    logic [`DC_WAY_BITS-1:0]     retire_way;
    logic [`DC_BLOCK_BITS-1:0]   retire_block;

    assign miss = load_valid && !hit;

    cache_array u_array (
        .clock        (clock),
        .reset        (reset),
        .lookup_addr  (load_addr),
        .lookup_valid (load_valid),
        .fill_valid   (retire_valid),
        .fill_addr    (retire_addr),
        .fill_way     (retire_way),
        .fill_data    (retire_block),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_block    (hit_block)
    );

    plru_tree u_plru (
        .clock        (clock),
        .reset        (reset),
        .lookup_set   (load_addr[`DC_OFFSET_BITS +: `DC_SET_BITS]),
        .victim_way   (victim_way),
        .hit_update   (hit),
        .hit_set      (load_addr[`DC_OFFSET_BITS +: `DC_SET_BITS]),
        .hit_way      (hit_way),
        .fill_update  (retire_valid),
        .fill_set     (retire_addr[`DC_OFFSET_BITS +: `DC_SET_BITS]),
        .fill_way     (retire_way)
    );

    // a hit holds the done head back for a cycle
    miss_buffer u_miss (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .enqueue       (miss),
        .load_addr     (load_addr),
        .load_size     (load_size),
        .load_signed   (load_signed),
        .load_rob      (load_rob),
        .victim_way    (victim_way),
        .hold_retire   (hit),
        .buffer_full   (buffer_full),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr),
        .mem_response  (mem_response),
        .mem_data      (mem_data),
        .mem_tag       (mem_tag),
        .retire_valid  (retire_valid),
        .retire_addr   (retire_addr),
        .retire_size   (retire_size),
        .retire_signed (retire_signed),
        .retire_rob    (retire_rob),
        .retire_way    (retire_way),
        .retire_block  (retire_block)
    );

    load_align u_align (
        .hit           (hit),
        .load_addr     (load_addr),
        .load_size     (load_size),
        .load_signed   (load_signed),
        .load_rob      (load_rob),
        .hit_block     (hit_block),
        .retire_valid  (retire_valid),
        .retire_addr   (retire_addr),
        .retire_size   (retire_size),
        .retire_signed (retire_signed),
        .retire_rob    (retire_rob),
        .retire_block  (retire_block),
        .result_valid  (result_valid),
        .result_value  (result_value),
        .result_rob    (result_rob)
    );

endmodule

// File: tests/dcache_asserts.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_asserts (
    input logic                         clock,
    input logic                         reset,
    input logic                         flush,
    input logic                         enqueue,
    input logic                         buffer_full,
    input dcache_pkg::bus_command_t     mem_command,
    input logic [`DC_ADDR_BITS-1:0]     mem_addr,
    input logic [`DC_MEM_TAG_BITS-1:0]  mem_response
);

    // read by the testbench at the end of the run
    int failures = 0;

    no_enqueue_when_full: assert property (
        @(posedge clock) disable iff (reset) buffer_full |-> !enqueue)
        else begin
            failures++;
            $error("miss enqueued while the buffer was full");
        end

    // buffer is empty after either clear
    idle_after_clear: assert property (
        @(posedge clock) (reset || flush) |=> (mem_command == dcache_pkg::bus_none))
        else begin
            failures++;
            $error("memory request still presented after reset or flush");
        end

    block_aligned_request: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command == dcache_pkg::bus_load) |-> (mem_addr[`DC_OFFSET_BITS-1:0] == '0))
        else begin
            failures++;
            $error("memory request address has nonzero offset bits");
        end

    // a refused request stays on the bus unchanged
    request_held_until_accepted: assert property (
        @(posedge clock) disable iff (reset || flush)
        (mem_command == dcache_pkg::bus_load && mem_response == '0)
        |=> (mem_command == dcache_pkg::bus_load && $stable(mem_addr)))
        else begin
            failures++;
            $error("memory request dropped or changed before it was accepted");
        end

endmodule

bind miss_buffer dcache_asserts miss_checks (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .enqueue      (enqueue),
    .buffer_full  (buffer_full),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response)
);

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

    // about 400 loads at up to 50 cycles each
    localparam int CYCLE_LIMIT = 20000;
    localparam int ROB_COUNT = 1 << `DC_ROB_BITS;

    logic                           clock;
    logic                           reset;
    logic                           flush;
    logic                           load_valid;
    logic [`DC_ADDR_BITS-1:0]       load_addr;
    dcache_pkg::mem_size_t          load_size;
    logic                           load_signed;
    logic [`DC_ROB_BITS-1:0]        load_rob;
    logic                           buffer_full;
    dcache_pkg::bus_command_t       mem_command;
    logic [`DC_ADDR_BITS-1:0]       mem_addr;
    logic [`DC_MEM_TAG_BITS-1:0]    mem_response;
    logic [`DC_BLOCK_BITS-1:0]      mem_data;
    logic [`DC_MEM_TAG_BITS-1:0]    mem_tag;
    logic                           result_valid;
    logic [`DC_WORD_BITS-1:0]       result_value;
    logic [`DC_ROB_BITS-1:0]        result_rob;

    // memory model state, indexed by transaction tag
    logic                           stall;
    logic                           grant;
    logic [`DC_MEM_TAG_BITS-1:0]    next_tag;
    logic [15:0]                    owed;
    int                             due [16];
    logic [`DC_ADDR_BITS-1:0]       owed_addr [16];

    // scoreboard
    logic [`DC_WORD_BITS-1:0]       exp_value [ROB_COUNT];
    logic                           must_hit [ROB_COUNT];
    logic [`DC_ROB_BITS-1:0]        miss_q [$];
    logic [`DC_ROB_BITS-1:0]        next_rob;
    logic [31:0]                    stim_lfsr;
    logic [31:0]                    mem_lfsr;
    int                             errors = 0;
    int                             results = 0;
    int                             cycles = 0;

    dcache DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'ha300_0000) : (state >> 1);
        end
        return value;
    endfunction

    // block contents depend on the whole block address
    function automatic logic [63:0] block_data(input logic [31:0] addr);
        logic [31:0] blk;
        blk = addr >> `DC_OFFSET_BITS;
        return {(blk ^ 32'h5a5a_f00f) * 32'h85eb_ca6b, blk * 32'h9e37_79b1 + 32'h1357_9bdf};
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input dcache_pkg::mem_size_t size,
                                                input logic sgn);
        logic [63:0] blk;
        logic [31:0] value;
        int nbytes;
        int off;
        blk = block_data({addr[31:3], 3'b000});
        off = addr[2:0];
        nbytes = (size == dcache_pkg::size_byte) ? 1 : (size == dcache_pkg::size_half) ? 2 : 4;
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = blk[8*(off+i) +: 8];
        end
        // fill the upper bytes with the sign
        if (sgn && value[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                value[8*i +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    task automatic issue_load(input logic [31:0] addr, input dcache_pkg::mem_size_t size,
                              input logic sgn, input logic hit_needed);
        @(negedge clock);
        while (buffer_full) @(negedge clock);
        @(posedge clock);
        exp_value[next_rob] = expect_load(addr, size, sgn);
        must_hit[next_rob]  = hit_needed;
        load_valid  <= 1'b1;
        load_addr   <= addr;
        load_size   <= size;
        load_signed <= sgn;
        load_rob    <= next_rob;
        next_rob     = next_rob + 1'b1;
        @(posedge clock);
        load_valid  <= 1'b0;
    endtask

    task automatic wait_idle;
        while (miss_q.size() != 0) @(negedge clock);
    endtask

    task automatic check_idle;
        if (result_valid !== 1'b0) begin
            errors++;
            $display("Error at %0t: result_valid = %b, expected 0", $time, result_valid);
        end
        if (mem_command !== dcache_pkg::bus_none) begin
            errors++;
            $display("Error at %0t: mem_command = %0d, expected %0d", $time, mem_command,
                     dcache_pkg::bus_none);
        end
        if (buffer_full !== 1'b0) begin
            errors++;
            $display("Error at %0t: buffer_full = %b, expected 0", $time, buffer_full);
        end
    endtask

    task automatic do_flush;
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        @(negedge clock);
        check_idle();
    endtask

    task automatic compare_value(input logic [`DC_ROB_BITS-1:0] rob);
        results++;
        if (result_value !== exp_value[rob]) begin
            errors++;
            $display("Error at %0t: result_value = %h, expected %h (rob %0d)", $time,
                     result_value, exp_value[rob], rob);
        end
    endtask

    // memory answers in the same cycle it sees a request
    assign mem_response = (mem_command == dcache_pkg::bus_load && grant && !owed[next_tag])
                        ? next_tag : '0;

    always @(posedge clock) begin : memory_model
        logic found;
        found = 1'b0;
        if (reset) begin
            grant    <= 1'b0;
            next_tag <= 4'd1;
            owed     <= '0;
            mem_tag  <= '0;
            mem_data <= '0;
        end else begin
            if (mem_command == dcache_pkg::bus_load && mem_response != '0) begin
                owed[next_tag]      <= 1'b1;
                due[next_tag]       <= cycles + 2 + int'(rand_bits(mem_lfsr, 3) % 5);
                owed_addr[next_tag] <= mem_addr;
                next_tag            <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            grant   <= !stall && (rand_bits(mem_lfsr, 2) != 0);
            mem_tag <= '0;
            // one return per cycle, whichever tag falls due first
            for (int t = 1; t < 16; t++) begin
                if (!found && owed[t] && due[t] <= cycles) begin
                    found = 1'b1;
                    mem_tag  <= t[3:0];
                    mem_data <= block_data(owed_addr[t]);
                    owed[t]  <= 1'b0;
                end
            end
        end
    end

    always @(negedge clock) begin : scoreboard
        logic hit_now;
        logic [`DC_ROB_BITS-1:0] expected_rob;
        hit_now = load_valid && result_valid && (result_rob == load_rob);
        if (reset) begin
            miss_q.delete();
        end else if (flush) begin
            // flushed misses never report
            miss_q.delete();
        end else begin
            if (load_valid && hit_now) begin
                compare_value(load_rob);
            end else if (load_valid) begin
                if (must_hit[load_rob]) begin
                    errors++;
                    $display("load with rob %0d missed at %0t where a hit was due",
                             load_rob, $time);
                end
                miss_q.push_back(load_rob);
            end
            if (result_valid && !hit_now) begin
                if (miss_q.size() == 0) begin
                    errors++;
                    $display("result for rob %0d at %0t with no miss outstanding",
                             result_rob, $time);
                end else begin
                    expected_rob = miss_q.pop_front();
                    if (result_rob !== expected_rob) begin
                        errors++;
                        $display("Error at %0t: result_rob = %0d, expected %0d", $time,
                                 result_rob, expected_rob);
                    end
                    compare_value(expected_rob);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        int sz;
        int fails;
        reset = 1'b1;
        flush = 1'b0;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = dcache_pkg::size_word;
        load_signed = 1'b0;
        load_rob = '0;
        stall = 1'b0;
        grant = 1'b0;
        next_tag = 4'd1;
        owed = '0;
        mem_tag = '0;
        mem_data = '0;
        next_rob = '0;
        stim_lfsr = 32'h190d;
        mem_lfsr = 32'h190d;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_idle();

        // miss through memory, then a same-cycle hit
        issue_load(32'h0000_1234, dcache_pkg::size_word, 1'b0, 1'b0);
        wait_idle();
        issue_load(32'h0000_1234, dcache_pkg::size_word, 1'b0, 1'b1);

        // every size, offset and sign on two cached blocks
        for (int b = 0; b < 2; b++) begin
            issue_load(32'h0002_0000 + b * 32'h88, dcache_pkg::size_word, 1'b0, 1'b0);
            wait_idle();
            for (int s = 0; s < 3; s++) begin
                for (int off = 0; off < 8; off += (1 << s)) begin
                    for (int sgn = 0; sgn < 2; sgn++) begin
                        issue_load(32'h0002_0000 + b * 32'h88 + off,
                                   dcache_pkg::mem_size_t'(s), sgn != 0, 1'b1);
                    end
                end
            end
        end

        // returns come back out of order
        for (int i = 0; i < 8; i++) begin
            issue_load(32'h0003_0000 + i * 32'h48, dcache_pkg::size_word, 1'b0, 1'b0);
        end
        wait_idle();

        // memory stalls, buffer fills up
        @(posedge clock);
        stall <= 1'b1;
        repeat (3) @(posedge clock);
        for (int i = 0; i < 8; i++) begin
            issue_load(32'h0004_0000 + i * 8, dcache_pkg::size_half, 1'b1, 1'b0);
        end
        repeat (10) @(negedge clock);
        if (buffer_full !== 1'b1) begin
            errors++;
            $display("Error at %0t: buffer_full = %b, expected 1", $time, buffer_full);
        end
        @(posedge clock);
        stall <= 1'b0;
        wait_idle();

        // flush with misses both accepted and waiting, then miss again
        issue_load(32'h0005_0000, dcache_pkg::size_word, 1'b0, 1'b0);
        issue_load(32'h0005_0040, dcache_pkg::size_byte, 1'b1, 1'b0);
        @(posedge clock);
        stall <= 1'b1;
        issue_load(32'h0005_0080, dcache_pkg::size_half, 1'b0, 1'b0);
        issue_load(32'h0005_00c0, dcache_pkg::size_byte, 1'b0, 1'b0);
        do_flush();
        stall <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            issue_load(32'h0005_0000 + i * 32'h40 + 4, dcache_pkg::size_word, 1'b1, 1'b0);
        end
        wait_idle();

        // random mix over more blocks than the cache holds
        for (int n = 0; n < 300; n++) begin
            sz = rand_bits(stim_lfsr, 2);
            if (sz == 3) begin
                sz = 2;
            end
            addr = 32'h0001_0000 + (rand_bits(stim_lfsr, 6) << 3)
                 + ((rand_bits(stim_lfsr, 3) >> sz) << sz);
            issue_load(addr, dcache_pkg::mem_size_t'(sz), rand_bits(stim_lfsr, 1) != 0, 1'b0);
        end
        wait_idle();
        repeat (10) @(posedge clock);

        fails = DUT.u_miss.miss_checks.failures;
        $display("results checked: %0d, errors: %0d, assertion failures: %0d",
                 results, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/cache_array.sv
verilog/plru_tree.sv
verilog/miss_buffer.sv
verilog/load_align.sv
verilog/dcache.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv
